/* filelist.f */
src/adc_regmap_pkg.sv
src/adc_bus_pkg.sv
src/reg_bus_router.sv
src/capture_ctrl_regs.sv
src/clk_freq_meter.sv
src/adc_capture_regs_top.sv
sim/adc_capture_regs_sva.sv
sim/tb_adc_capture_regs.sv

/* Bender.yml */
package:
  name: adc_capture_regs

sources:
  - files:
      - src/adc_regmap_pkg.sv
      - src/adc_bus_pkg.sv
      - src/reg_bus_router.sv
      - src/capture_ctrl_regs.sv
      - src/clk_freq_meter.sv
      - src/adc_capture_regs_top.sv
  - target: test
    files:
      - sim/adc_capture_regs_sva.sv
      - sim/tb_adc_capture_regs.sv

/* sim/tb_adc_capture_regs.sv */
`timescale 1ns/1ns

module tb_adc_capture_regs;

   localparam int CLK_PERIOD   = 100;
   localparam int SCLK_PERIOD  = 350;
   localparam int DRIVE_DELAY  = 10;
   localparam int NUM_RAND_OPS = 80;
   localparam int ARM_MAX      = 4;   // sample clock cycles
   localparam int GATE         = adc_regmap_pkg::FREQ_GATE_CYCLES;
   localparam int FREQ_NOM     = GATE * CLK_PERIOD / SCLK_PERIOD;
   // reset, defaults, random ops, arm, soft reset, then three meter windows
   localparam int RUN_CYCLES   = 5 + 40 + 3 * NUM_RAND_OPS + 60 + 80 + 3 * GATE;

   logic                       clk_usb;
   logic                       adc_sampleclk_i;
   logic                       reset_i;
   logic                       reset_o;
   logic                       cmd_arm_o;
   logic                       freq_valid_o;
   adc_bus_pkg::reg_req_t      host_req_i;
   adc_bus_pkg::trig_ctrl_t    trig_ctrl_o;
   adc_bus_pkg::capture_cfg_t  capture_cfg_o;
   adc_regmap_pkg::reg_byte_t  rdata_o;
   adc_regmap_pkg::reg_byte_t  status_i;
   adc_regmap_pkg::freq_t      freq_o;

   logic [31:0] lcg_state;
   int          errors;
   int          checks;
   int          tests;
   int          test_start_errors;

   // expected register contents
   adc_regmap_pkg::gain_t        m_gain;
   adc_regmap_pkg::settings_t    m_settings;
   adc_regmap_pkg::reg_byte_t    m_echo;
   adc_regmap_pkg::offset_t      m_offset;
   adc_regmap_pkg::samples_t     m_samples;
   adc_regmap_pkg::presamples_t  m_presamples;
   logic                         m_soft_reset;

   always #(CLK_PERIOD / 2) clk_usb = ~clk_usb;
   always #(SCLK_PERIOD / 2) adc_sampleclk_i = ~adc_sampleclk_i;

   adc_capture_regs_top i_dut (.*);

   function automatic logic [31:0] lcg_next();
      lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
      return lcg_state;  // callers use the upper bits
   endfunction

   function automatic void model_reset();
      m_gain       = '0;
      m_settings   = adc_regmap_pkg::SETTINGS_RESET;
      m_echo       = '0;
      m_offset     = '0;
      m_samples    = adc_regmap_pkg::SAMPLES_RESET;
      m_presamples = '0;
   endfunction

   function automatic void model_write(input adc_regmap_pkg::reg_addr_t addr, input int bc,
                                       input adc_regmap_pkg::reg_byte_t data);
      logic [31:0] keep;
      logic [31:0] put;
      keep = ~(32'hff << (8 * bc));
      put  = 32'(data) << (8 * bc);
      if (addr == adc_regmap_pkg::ADDR_RESET) begin
         m_soft_reset = data[0];
         if (data[0])
            model_reset();
      end else if (!m_soft_reset) begin  // held registers ignore writes
         case (addr)
            adc_regmap_pkg::ADDR_GAIN:     m_gain     = data;
            adc_regmap_pkg::ADDR_SETTINGS: m_settings = data;
            adc_regmap_pkg::ADDR_ECHO:     m_echo     = data;
            adc_regmap_pkg::ADDR_OFFSET:   m_offset   = (m_offset & keep) | put;
            adc_regmap_pkg::ADDR_SAMPLES:  m_samples  = (m_samples & keep) | put;
            adc_regmap_pkg::ADDR_PRESAMPLES:
               m_presamples = 15'((32'(m_presamples) & keep) | put);
            default: ;
         endcase
      end
   endfunction

   function automatic adc_regmap_pkg::reg_byte_t model_read(
         input adc_regmap_pkg::reg_addr_t addr, input int bc);
      logic [31:0] word;
      word = '0;
      case (addr)
         adc_regmap_pkg::ADDR_GAIN:       word = 32'(m_gain);
         adc_regmap_pkg::ADDR_SETTINGS:   word = 32'(m_settings);
         adc_regmap_pkg::ADDR_STATUS:     word = 32'(status_i);
         adc_regmap_pkg::ADDR_ECHO:       word = 32'(m_echo);
         adc_regmap_pkg::ADDR_OFFSET:     word = m_offset;
         adc_regmap_pkg::ADDR_SAMPLES:    word = m_samples;
         adc_regmap_pkg::ADDR_PRESAMPLES: word = 32'(m_presamples);
         adc_regmap_pkg::ADDR_VERSION:
            word = {16'h0, adc_regmap_pkg::HW_TYPE, adc_regmap_pkg::HW_VER, 4'h0,
                    adc_regmap_pkg::REGMAP_VERSION};
         adc_regmap_pkg::ADDR_RESET:      word = 32'(m_soft_reset);
         default: ;
      endcase
      if (addr inside {adc_regmap_pkg::ADDR_OFFSET, adc_regmap_pkg::ADDR_SAMPLES,
                       adc_regmap_pkg::ADDR_PRESAMPLES, adc_regmap_pkg::ADDR_VERSION})
         word = word >> (8 * bc);  // single byte registers ignore bytecnt
      return word[7:0];
   endfunction

   task automatic report(input string name, input logic [63:0] exp, input logic [63:0] got);
      errors++;
      $display("Error at %0t ns: %s expected %0h got %0h", $time, name, exp, got);
   endtask

   task automatic check_byte(input string name, input adc_regmap_pkg::reg_byte_t exp,
                             input adc_regmap_pkg::reg_byte_t got);
      checks++;
      if (got !== exp)
         report(name, 64'(exp), 64'(got));
   endtask

   task automatic check_trig(input string name, input adc_bus_pkg::trig_ctrl_t exp,
                             input adc_bus_pkg::trig_ctrl_t got);
      checks++;
      if (got !== exp)
         report(name, 64'(exp), 64'(got));
   endtask

   task automatic check_cfg(input string name, input adc_bus_pkg::capture_cfg_t exp,
                            input adc_bus_pkg::capture_cfg_t got);
      checks++;
      if (got !== exp)
         report(name, 64'(exp), 64'(got));
   endtask

   task automatic check_freq(input string name, input adc_regmap_pkg::freq_t exp,
                             input adc_regmap_pkg::freq_t got);
      checks++;
      if (got !== exp)
         report(name, 64'(exp), 64'(got));
   endtask

   task automatic bus_access(input logic wr, input adc_regmap_pkg::reg_addr_t addr, input int bc,
                             input adc_regmap_pkg::reg_byte_t data,
                             output adc_regmap_pkg::reg_byte_t rd_byte);
      @(posedge clk_usb);
      #DRIVE_DELAY;
      host_req_i.address = addr;
      host_req_i.bytecnt = 7'(bc);
      host_req_i.wdata   = data;
      host_req_i.wr      = wr;
      host_req_i.rd      = ~wr;
      @(posedge clk_usb);
      #DRIVE_DELAY;
      host_req_i.wr = 1'b0;
      host_req_i.rd = 1'b0;
      rd_byte = rdata_o;  // valid in the cycle after the strobe
      if (wr)
         model_write(addr, bc, data);
   endtask

   task automatic write_reg(input adc_regmap_pkg::reg_addr_t addr, input int bc,
                            input adc_regmap_pkg::reg_byte_t data);
      adc_regmap_pkg::reg_byte_t ignored;
      bus_access(1'b1, addr, bc, data, ignored);
   endtask

   task automatic read_check(input adc_regmap_pkg::reg_addr_t addr, input int bc);
      adc_regmap_pkg::reg_byte_t got;
      bus_access(1'b0, addr, bc, 8'h00, got);
      check_byte($sformatf("rdata_o (addr %0d byte %0d)", addr, bc), model_read(addr, bc), got);
   endtask

   task automatic read_all_regs();
      int nbytes;
      for (int a = 0; a <= 8; a++) begin
         nbytes = (a == 4 || a == 5) ? 4 : (a == 6 || a == 7) ? 2 : 1;
         for (int b = 0; b < nbytes; b++)
            read_check(8'(a), b);
      end
   endtask

   task automatic check_outputs();
      adc_bus_pkg::trig_ctrl_t   exp_trig;
      adc_bus_pkg::capture_cfg_t exp_cfg;
      exp_trig.trig_mode   = m_settings[adc_regmap_pkg::SET_TRIG_MODE];
      exp_trig.trig_wait   = m_settings[adc_regmap_pkg::SET_TRIG_WAIT];
      exp_trig.trig_now    = m_settings[adc_regmap_pkg::SET_TRIG_NOW];
      exp_trig.trig_src    = m_settings[adc_regmap_pkg::SET_TRIG_SRC];
      exp_trig.fifo_stream = m_settings[adc_regmap_pkg::SET_STREAM];
      exp_trig.offset      = m_offset;
      exp_cfg = {m_gain, m_samples, m_presamples};
      check_trig("trig_ctrl_o", exp_trig, trig_ctrl_o);
      check_cfg("capture_cfg_o", exp_cfg, capture_cfg_o);
   endtask

   task automatic wait_arm(input logic level);
      int n;
      n = 0;
      while (cmd_arm_o !== level && n < ARM_MAX) begin
         @(posedge adc_sampleclk_i);
         #1;
         n++;
      end
      checks++;
      if (cmd_arm_o !== level) begin
         errors++;
         $display("cmd_arm_o did not reach %0b within %0d sample clock cycles", level, ARM_MAX);
      end
   endtask

   task automatic finish_test(input string name);
      tests++;
      $display("test %-12s %s (%0d errors)", name,
               (errors == test_start_errors) ? "ok" : "FAILED", errors - test_start_errors);
      test_start_errors = errors;
   endtask

   initial begin
      logic [31:0]               r;
      adc_regmap_pkg::reg_addr_t addr;
      adc_regmap_pkg::settings_t settings;
      adc_regmap_pkg::reg_byte_t got;
      adc_regmap_pkg::freq_t     rd_freq;
      int                        n;
      clk_usb           = 1'b0;
      adc_sampleclk_i   = 1'b0;
      reset_i           = 1'b1;
      host_req_i        = '0;
      status_i          = '0;
      lcg_state         = 32'h7e4d;
      errors            = 0;
      checks            = 0;
      tests             = 0;
      test_start_errors = 0;
      m_soft_reset      = 1'b0;
      model_reset();
      repeat (5) @(posedge clk_usb);
      #DRIVE_DELAY;
      reset_i = 1'b0;

      r = lcg_next();
      status_i = r[23:16];
      read_all_regs();
      check_outputs();
      check_byte("cmd_arm_o", 8'h00, 8'(cmd_arm_o));
      finish_test("defaults");

      for (int i = 0; i < NUM_RAND_OPS; i++) begin
         r = lcg_next();
         if (r[31]) begin
            write_reg(8'(r[29:27]), r[26:25], r[23:16]);  // includes read only addresses
            check_outputs();
         end else begin
            status_i = r[23:16];
            addr = r[24] ? 8'(r[30:27] % 9) : r[15:8];
            if (!r[24] && (addr <= adc_regmap_pkg::ADDR_RESET ||
                           addr == adc_regmap_pkg::ADDR_EXTFREQ))
               addr = 8'd40;  // unused meter address
            read_check(addr, r[26:25]);
         end
      end
      finish_test("random");

      settings = m_settings;
      for (int k = 0; k < 3; k++) begin  // clear, set, clear
         settings[adc_regmap_pkg::SET_ARM] = k[0];
         write_reg(adc_regmap_pkg::ADDR_SETTINGS, 0, settings);
         wait_arm(k[0]);
      end
      finish_test("arm_sync");

      write_reg(adc_regmap_pkg::ADDR_RESET, 0, 8'h01);
      check_byte("reset_o", 8'h01, 8'(reset_o));
      @(posedge clk_usb);  // registers clear on the following edge
      #DRIVE_DELAY;
      check_outputs();
      read_all_regs();
      r = lcg_next();
      write_reg(adc_regmap_pkg::ADDR_GAIN, 0, r[31:24]);
      read_check(adc_regmap_pkg::ADDR_GAIN, 0);
      write_reg(adc_regmap_pkg::ADDR_RESET, 0, 8'h00);
      check_byte("reset_o", 8'h00, 8'(reset_o));
      write_reg(adc_regmap_pkg::ADDR_GAIN, 0, r[23:16]);
      write_reg(adc_regmap_pkg::ADDR_SAMPLES, 2, r[15:8]);
      check_outputs();
      read_check(adc_regmap_pkg::ADDR_GAIN, 0);
      read_check(adc_regmap_pkg::ADDR_SAMPLES, 2);
      finish_test("soft_reset");

      // meter window restarted at the release above
      n = 0;
      while (freq_valid_o !== 1'b1 && n < GATE + 10) begin
         @(posedge clk_usb);
         #DRIVE_DELAY;
         n++;
      end
      checks++;
      if (freq_valid_o !== 1'b1) begin
         errors++;
         $display("no freq_valid_o pulse within one gate window");
      end else begin
         for (int b = 0; b < 4; b++) begin
            bus_access(1'b0, adc_regmap_pkg::ADDR_EXTFREQ, b, 8'h00, got);
            rd_freq[8*b +: 8] = got;
         end
         check_freq("rdata_o (ADDR_EXTFREQ)", freq_o, rd_freq);
         checks++;
         if (freq_o < FREQ_NOM - 1 || freq_o > FREQ_NOM + 1)
            report("freq_o", 64'(FREQ_NOM), 64'(freq_o));
      end
      finish_test("freq_meter");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

   initial begin
      #(RUN_CYCLES * CLK_PERIOD);
      $display("watchdog expired after %0d clk_usb cycles", RUN_CYCLES);
      $display("Simulation failed");
      $finish;
   end

endmodule

/* sim/adc_capture_regs_sva.sv */
`timescale 1ns/1ns

module adc_capture_regs_sva (
   input logic                       clk_usb,
   input logic                       reset_i,
   input logic                       reset_o,
   input adc_bus_pkg::reg_req_t      host_req_i,
   input adc_regmap_pkg::reg_byte_t  rdata_o
);

   logic reset_wr;  // host write to the soft reset register

   assign reset_wr = host_req_i.wr &&
                     (host_req_i.address == adc_regmap_pkg::ADDR_RESET);

   rd_wr_exclusive: assert property (@(posedge clk_usb) disable iff (reset_i)
      !(host_req_i.rd && host_req_i.wr))
      else $error("read and write strobes high in the same cycle");

   // read data only in the cycle after a read strobe
   rdata_idle_zero: assert property (@(posedge clk_usb) disable iff (reset_i)
      !$past(host_req_i.rd) |-> rdata_o == '0)
      else $error("rdata_o nonzero without a read in the previous cycle");

   soft_reset_sets: assert property (@(posedge clk_usb) disable iff (reset_i)
      reset_wr && host_req_i.wdata[0] |=> reset_o)
      else $error("reset_o not raised after writing 1 to the soft reset register");

   // held until 0 is written
   soft_reset_holds: assert property (@(posedge clk_usb) disable iff (reset_i)
      reset_o && !(reset_wr && !host_req_i.wdata[0]) |=> reset_o)
      else $error("reset_o low while the soft reset register is set");

endmodule

bind adc_capture_regs_top adc_capture_regs_sva i_sva (
   .clk_usb      (clk_usb),
   .reset_i      (reset_i),
   .reset_o      (reset_o),
   .host_req_i   (host_req_i),
   .rdata_o      (rdata_o)
);

/* src/adc_capture_regs_top.sv */
`timescale 1ns/1ns

module adc_capture_regs_top (
   input  logic                       clk_usb,
   input  logic                       adc_sampleclk_i,
   input  logic                       reset_i,
   output logic                       reset_o,
   input  adc_bus_pkg::reg_req_t      host_req_i,
   output adc_regmap_pkg::reg_byte_t  rdata_o,
   input  adc_regmap_pkg::reg_byte_t  status_i,
   output adc_bus_pkg::trig_ctrl_t    trig_ctrl_o,
   output adc_bus_pkg::capture_cfg_t  capture_cfg_o,
   output logic                       cmd_arm_o,
   output adc_regmap_pkg::freq_t      freq_o,
   output logic                       freq_valid_o
);

   adc_bus_pkg::reg_req_t      ctrl_req;
   adc_bus_pkg::reg_req_t      meter_req;
   adc_regmap_pkg::reg_byte_t  ctrl_rdata;
   adc_regmap_pkg::reg_byte_t  meter_rdata;

   // router runs on the external reset so reads work during soft reset
   reg_bus_router i_router (
      .clk_usb       (clk_usb),
      .reset         (reset_i),
      .host_req_i    (host_req_i),
      .ctrl_req_o    (ctrl_req),
      .meter_req_o   (meter_req),
      .ctrl_rdata_i  (ctrl_rdata),
      .meter_rdata_i (meter_rdata),
      .rdata_o       (rdata_o)
   );

   capture_ctrl_regs i_ctrl (
      .clk_usb         (clk_usb),
      .adc_sampleclk_i (adc_sampleclk_i),
      .reset_i         (reset_i),
      .reset_o         (reset_o),
      .req_i           (ctrl_req),
      .rdata_o         (ctrl_rdata),
      .status_i        (status_i),
      .trig_ctrl_o     (trig_ctrl_o),
      .capture_cfg_o   (capture_cfg_o),
      .cmd_arm_o       (cmd_arm_o)
   );

   clk_freq_meter i_meter (
      .clk_usb      (clk_usb),
      .reset        (reset_o),          // combined external and soft reset
      .meas_clk_i   (adc_sampleclk_i),
      .req_i        (meter_req),
      .rdata_o      (meter_rdata),
      .freq_o       (freq_o),
      .freq_valid_o (freq_valid_o)
   );

endmodule

/* src/clk_freq_meter.sv */
`timescale 1ns/1ns

module clk_freq_meter (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  logic                       meas_clk_i,
   input  adc_bus_pkg::reg_req_t      req_i,
   output adc_regmap_pkg::reg_byte_t  rdata_o,
   output adc_regmap_pkg::freq_t      freq_o,
   output logic                       freq_valid_o
);

   logic [2:0]                 meas_sync;  // two sync stages and edge history
   logic                       meas_rise;
   logic                       gate_end;
   adc_regmap_pkg::gate_cnt_t  gate_cnt;
   adc_regmap_pkg::freq_t      edge_cnt;

   assign meas_rise = meas_sync[1] & ~meas_sync[2];
   assign gate_end  = (gate_cnt == adc_regmap_pkg::gate_cnt_t'(
                          adc_regmap_pkg::FREQ_GATE_CYCLES - 1));

   // meas_clk_i must stay below half of clk_usb for edges to be seen
   always_ff @(posedge clk_usb) begin
      if (reset)
         meas_sync <= '0;
      else
         meas_sync <= {meas_sync[1:0], meas_clk_i};
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gate_cnt     <= '0;
         edge_cnt     <= '0;
         freq_o       <= '0;
         freq_valid_o <= 1'b0;
      end else begin
         freq_valid_o <= gate_end;
         if (gate_end) begin
            gate_cnt <= '0;
            edge_cnt <= '0;
            freq_o   <= edge_cnt + 32'(meas_rise);  // include the last cycle's edge
         end else begin
            gate_cnt <= gate_cnt + 1'b1;
            edge_cnt <= edge_cnt + 32'(meas_rise);
         end
      end
   end

   always_ff @(posedge clk_usb) begin
      if (req_i.rd && (req_i.address == adc_regmap_pkg::ADDR_EXTFREQ))
         rdata_o <= adc_regmap_pkg::get_byte(freq_o, req_i.bytecnt);
      else
         rdata_o <= '0;  // other meter addresses read zero
   end

endmodule

/* src/capture_ctrl_regs.sv */
`timescale 1ns/1ns

module capture_ctrl_regs (
   input  logic                         clk_usb,
   input  logic                         adc_sampleclk_i,
   input  logic                         reset_i,
   output logic                         reset_o,
   input  adc_bus_pkg::reg_req_t        req_i,
   output adc_regmap_pkg::reg_byte_t    rdata_o,
   input  adc_regmap_pkg::reg_byte_t    status_i,
   output adc_bus_pkg::trig_ctrl_t      trig_ctrl_o,
   output adc_bus_pkg::capture_cfg_t    capture_cfg_o,
   output logic                         cmd_arm_o
);

   logic                          reset;         // external or soft reset
   logic                          soft_reset;
   logic                          cmd_arm_usb;

   adc_regmap_pkg::gain_t         gain_q;
   adc_regmap_pkg::settings_t     settings_q;
   adc_regmap_pkg::reg_byte_t     echo_q;        // scratch byte for the host
   adc_regmap_pkg::offset_t       offset_q;
   adc_regmap_pkg::samples_t      samples_q;
   adc_regmap_pkg::presamples_t   presamples_q;

   logic [1:0]                    arm_sync;      // first two sample clock stages
   logic                          arm_r;
   logic                          arm_r2;

   // replace one byte of a word, writes past the top byte are dropped
   function automatic logic [31:0] put_byte(input logic [31:0] word,
                                            input adc_regmap_pkg::reg_bytecnt_t idx,
                                            input adc_regmap_pkg::reg_byte_t data);
      logic [31:0] res;
      res = word;
      if (idx < 7'd4)
         res[{idx[1:0], 3'b000} +: 8] = data;
      return res;
   endfunction

   assign reset   = reset_i | soft_reset;
   assign reset_o = reset;

   // the soft reset bit only clears on the external reset
   // so writing 1 holds everything else in reset until 0 is written
   always_ff @(posedge clk_usb) begin
      if (reset_i)
         soft_reset <= 1'b0;
      else if (req_i.wr && (req_i.address == adc_regmap_pkg::ADDR_RESET))
         soft_reset <= req_i.wdata[0];
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         gain_q       <= '0;
         settings_q   <= adc_regmap_pkg::SETTINGS_RESET;
         echo_q       <= '0;
         offset_q     <= '0;
         samples_q    <= adc_regmap_pkg::SAMPLES_RESET;
         presamples_q <= '0;
      end else if (req_i.wr) begin
         case (req_i.address)
            adc_regmap_pkg::ADDR_GAIN:     gain_q     <= req_i.wdata;
            adc_regmap_pkg::ADDR_SETTINGS: settings_q <= req_i.wdata;
            adc_regmap_pkg::ADDR_ECHO:     echo_q     <= req_i.wdata;
            adc_regmap_pkg::ADDR_OFFSET:
               offset_q <= put_byte(offset_q, req_i.bytecnt, req_i.wdata);
            adc_regmap_pkg::ADDR_SAMPLES:
               samples_q <= put_byte(samples_q, req_i.bytecnt, req_i.wdata);
            adc_regmap_pkg::ADDR_PRESAMPLES:
               presamples_q <= adc_regmap_pkg::presamples_t'(
                  put_byte(32'(presamples_q), req_i.bytecnt, req_i.wdata));
            default: ;  // read only or unmapped
         endcase
      end
   end

   // read byte is registered, zero when no read
   always_ff @(posedge clk_usb) begin
      if (req_i.rd) begin
         case (req_i.address)
            adc_regmap_pkg::ADDR_GAIN:     rdata_o <= gain_q;
            adc_regmap_pkg::ADDR_SETTINGS: rdata_o <= settings_q;
            adc_regmap_pkg::ADDR_STATUS:   rdata_o <= status_i;
            adc_regmap_pkg::ADDR_ECHO:     rdata_o <= echo_q;
            adc_regmap_pkg::ADDR_OFFSET:
               rdata_o <= adc_regmap_pkg::get_byte(offset_q, req_i.bytecnt);
            adc_regmap_pkg::ADDR_SAMPLES:
               rdata_o <= adc_regmap_pkg::get_byte(samples_q, req_i.bytecnt);
            adc_regmap_pkg::ADDR_PRESAMPLES:
               rdata_o <= adc_regmap_pkg::get_byte(32'(presamples_q), req_i.bytecnt);
            adc_regmap_pkg::ADDR_VERSION:
               rdata_o <= adc_regmap_pkg::get_byte(32'(adc_regmap_pkg::VERSION_WORD),
                                                   req_i.bytecnt);
            adc_regmap_pkg::ADDR_RESET:    rdata_o <= {7'b0, soft_reset};
            default:                       rdata_o <= '0;
         endcase
      end else begin
         rdata_o <= '0;
      end
   end

   always_comb begin
      trig_ctrl_o.trig_mode   = settings_q[adc_regmap_pkg::SET_TRIG_MODE];
      trig_ctrl_o.trig_wait   = settings_q[adc_regmap_pkg::SET_TRIG_WAIT];
      trig_ctrl_o.trig_now    = settings_q[adc_regmap_pkg::SET_TRIG_NOW];
      trig_ctrl_o.trig_src    = settings_q[adc_regmap_pkg::SET_TRIG_SRC];
      trig_ctrl_o.fifo_stream = settings_q[adc_regmap_pkg::SET_STREAM];
      trig_ctrl_o.offset      = offset_q;
   end

   always_comb begin
      capture_cfg_o.gain       = gain_q;
      capture_cfg_o.samples    = samples_q;
      capture_cfg_o.presamples = presamples_q;
   end

   assign cmd_arm_usb = settings_q[adc_regmap_pkg::SET_ARM];

   // arm crosses into the sample clock domain
   always_ff @(posedge adc_sampleclk_i) begin
      if (reset) begin
         arm_sync <= '0;
         arm_r    <= 1'b0;
         arm_r2   <= 1'b0;
      end else begin
         arm_sync <= {arm_sync[0], cmd_arm_usb};
         arm_r    <= arm_sync[1];  // extra stages before the trigger unit
         arm_r2   <= arm_r;
      end
   end

   assign cmd_arm_o = arm_r2;

endmodule

/* src/reg_bus_router.sv */
`timescale 1ns/1ns

module reg_bus_router (
   input  logic                       clk_usb,
   input  logic                       reset,
   input  adc_bus_pkg::reg_req_t      host_req_i,
   output adc_bus_pkg::reg_req_t      ctrl_req_o,
   output adc_bus_pkg::reg_req_t      meter_req_o,
   input  adc_regmap_pkg::reg_byte_t  ctrl_rdata_i,
   input  adc_regmap_pkg::reg_byte_t  meter_rdata_i,
   output adc_regmap_pkg::reg_byte_t  rdata_o
);

   logic ctrl_hit;
   logic meter_hit;
   logic ctrl_rd_q;   // last cycle read went to control block
   logic meter_rd_q;  // last cycle read went to meter

   assign ctrl_hit  = (host_req_i.address >= adc_regmap_pkg::CTRL_BASE) &&
                      (host_req_i.address <= adc_regmap_pkg::CTRL_LIMIT);
   assign meter_hit = (host_req_i.address >= adc_regmap_pkg::METER_BASE) &&
                      (host_req_i.address <= adc_regmap_pkg::METER_LIMIT);

   always_comb begin
      ctrl_req_o     = host_req_i;
      ctrl_req_o.rd  = host_req_i.rd & ctrl_hit;
      ctrl_req_o.wr  = host_req_i.wr & ctrl_hit;
      meter_req_o    = host_req_i;
      meter_req_o.rd = host_req_i.rd & meter_hit;
      meter_req_o.wr = host_req_i.wr & meter_hit;
   end

   always_ff @(posedge clk_usb) begin
      if (reset) begin
         ctrl_rd_q  <= 1'b0;
         meter_rd_q <= 1'b0;
      end else begin
         ctrl_rd_q  <= host_req_i.rd & ctrl_hit;
         meter_rd_q <= host_req_i.rd & meter_hit;
      end
   end

   // unmapped reads select neither peer and return zero
   assign rdata_o = ctrl_rd_q  ? ctrl_rdata_i  :
                    meter_rd_q ? meter_rdata_i : '0;

endmodule

/* src/adc_bus_pkg.sv */
package adc_bus_pkg;

   // one host access, strobes last a single clk_usb cycle
   typedef struct packed {
      adc_regmap_pkg::reg_addr_t    address;
      adc_regmap_pkg::reg_bytecnt_t bytecnt;
      adc_regmap_pkg::reg_byte_t    wdata;
      logic                         rd;
      logic                         wr;
   } reg_req_t;

   // trigger unit controls
   typedef struct packed {
      logic                      trig_mode;    // 1 = rising edge
      logic                      trig_wait;
      logic                      trig_now;     // force a trigger
      logic                      trig_src;
      logic                      fifo_stream;  // streaming capture
      adc_regmap_pkg::offset_t   offset;
   } trig_ctrl_t;

   // capture FIFO configuration
   typedef struct packed {
      adc_regmap_pkg::gain_t       gain;
      adc_regmap_pkg::samples_t    samples;
      adc_regmap_pkg::presamples_t presamples;
   } capture_cfg_t;

endpackage

/* src/adc_regmap_pkg.sv */
package adc_regmap_pkg;

   typedef logic [7:0]  reg_addr_t;     // host bus register address
   typedef logic [6:0]  reg_bytecnt_t;  // byte index inside a register
   typedef logic [7:0]  reg_byte_t;     // one data byte
   typedef logic [7:0]  gain_t;
   typedef logic [7:0]  settings_t;
   typedef logic [31:0] offset_t;       // trigger offset in samples
   typedef logic [31:0] samples_t;      // capture length
   typedef logic [14:0] presamples_t;
   typedef logic [31:0] freq_t;         // edges per gate window

   // control block register map
   localparam reg_addr_t ADDR_GAIN       = 8'd0;
   localparam reg_addr_t ADDR_SETTINGS   = 8'd1;
   localparam reg_addr_t ADDR_STATUS     = 8'd2;   // read only
   localparam reg_addr_t ADDR_ECHO       = 8'd3;
   localparam reg_addr_t ADDR_OFFSET     = 8'd4;
   localparam reg_addr_t ADDR_SAMPLES    = 8'd5;
   localparam reg_addr_t ADDR_PRESAMPLES = 8'd6;
   localparam reg_addr_t ADDR_VERSION    = 8'd7;   // read only, two bytes
   localparam reg_addr_t ADDR_RESET      = 8'd8;

   // frequency meter register map
   localparam reg_addr_t ADDR_EXTFREQ    = 8'd32;  // read only, four bytes

   // address window of each peer on the shared bus
   localparam reg_addr_t CTRL_BASE   = 8'd0;
   localparam reg_addr_t CTRL_LIMIT  = 8'd31;
   localparam reg_addr_t METER_BASE  = 8'd32;
   localparam reg_addr_t METER_LIMIT = 8'd47;

   localparam settings_t SETTINGS_RESET = 8'h24;      // rising edge, wait enabled
   localparam samples_t  SAMPLES_RESET  = 32'd98000;  // default max capture length

   // bit positions in the settings register
   localparam int SET_TRIG_MODE = 2;
   localparam int SET_ARM       = 3;
   localparam int SET_STREAM    = 4;
   localparam int SET_TRIG_WAIT = 5;
   localparam int SET_TRIG_NOW  = 6;
   localparam int SET_TRIG_SRC  = 7;

   localparam logic [4:0] HW_TYPE        = 5'd8;
   localparam logic [2:0] HW_VER         = 3'd1;
   localparam logic [3:0] REGMAP_VERSION = 4'd1;
   localparam logic [15:0] VERSION_WORD  = {HW_TYPE, HW_VER, 4'h0, REGMAP_VERSION};

   localparam int FREQ_GATE_CYCLES = 1000;  // window length in clk_usb cycles
   localparam int GATE_CNT_W       = $clog2(FREQ_GATE_CYCLES);

   typedef logic [GATE_CNT_W-1:0] gate_cnt_t;

   // byte of a word picked by bytecnt, zero past the top byte
   function automatic reg_byte_t get_byte(input logic [31:0] word,
                                          input reg_bytecnt_t idx);
      reg_byte_t res;
      res = '0;
      if (idx < 7'd4)
         res = word[{idx[1:0], 3'b000} +: 8];
      return res;
   endfunction

endpackage
